// ==== design/decompressor.sv ====
`timescale 1ns/100ps

module decompressor (
  input  logic [15:0]              c_instr,
  output rvc_pkg::instruction_type c_expanded,
  output logic                     c_illegal
);
  import rvc_pkg::*;

  // Matched on {funct3, op}
  localparam logic [4:0] C_LW   = {3'b010, 2'b00};
  localparam logic [4:0] C_SW   = {3'b110, 2'b00};
  localparam logic [4:0] C_ADDI = {3'b000, 2'b01};
  localparam logic [4:0] C_LI   = {3'b010, 2'b01};
  localparam logic [4:0] C_LUI  = {3'b011, 2'b01};
  localparam logic [4:0] C_BEQZ = {3'b110, 2'b01};
  localparam logic [4:0] C_BNEZ = {3'b111, 2'b01};
  localparam logic [4:0] C_SLLI = {3'b000, 2'b10};

  // Matched on {funct4, op}
  localparam logic [5:0] C_MV  = {3'b100, 1'b0, 2'b10};
  localparam logic [5:0] C_ADD = {3'b100, 1'b1, 2'b10};

  // Matched on {funct3, funct2 at 11:10, op}
  localparam logic [6:0] C_SRLI = {3'b100, 2'b00, 2'b01};
  localparam logic [6:0] C_SRAI = {3'b100, 2'b01, 2'b01};
  localparam logic [6:0] C_ANDI = {3'b100, 2'b10, 2'b01};

  // Matched on {funct6, funct2 at 6:5, op}
  localparam logic [9:0] C_SUB = {3'b100, 1'b0, 2'b11, 2'b00, 2'b01};
  localparam logic [9:0] C_XOR = {3'b100, 1'b0, 2'b11, 2'b01, 2'b01};
  localparam logic [9:0] C_OR  = {3'b100, 1'b0, 2'b11, 2'b10, 2'b01};
  localparam logic [9:0] C_AND = {3'b100, 1'b0, 2'b11, 2'b11, 2'b01};

  logic [4:0]  key5;
  logic [5:0]  key6;
  logic [6:0]  key7;
  logic [9:0]  key10;
  logic [4:0]  rd_full;
  logic [4:0]  rs2_full;
  logic [4:0]  rs1_prime;
  logic [4:0]  rs2_prime;
  logic [11:0] imm6_sext;
  logic [11:0] mem_off;
  logic [12:0] br_off;
  logic [19:0] lui_imm;

  assign key5  = {c_instr[15:13], c_instr[1:0]};
  assign key6  = {c_instr[15:12], c_instr[1:0]};
  assign key7  = {c_instr[15:13], c_instr[11:10], c_instr[1:0]};
  assign key10 = {c_instr[15:10], c_instr[6:5], c_instr[1:0]};

  assign rd_full  = c_instr[11:7];
  assign rs2_full = c_instr[6:2];

  // Three-bit register fields reach x8 to x15
  assign rs1_prime = {2'b01, c_instr[9:7]};
  assign rs2_prime = {2'b01, c_instr[4:2]};

  assign imm6_sext = {{6{c_instr[12]}}, c_instr[12], c_instr[6:2]};
  assign mem_off   = {5'b0, c_instr[5], c_instr[12:10], c_instr[6], 2'b00};
  assign br_off    = {{4{c_instr[12]}}, c_instr[12], c_instr[6:5], c_instr[2],
                      c_instr[11:10], c_instr[4:3], 1'b0};
  assign lui_imm   = {{14{c_instr[12]}}, c_instr[12], c_instr[6:2]};

  always_comb begin
    c_expanded = '0;
    c_illegal  = 1'b0;
    if (key5 == C_LW) begin
      c_expanded.opcode = OP_LOAD;
      c_expanded.funct3 = F3_LW;
      c_expanded.rd     = rs2_prime;
      c_expanded.rs1    = rs1_prime;
      {c_expanded.funct7, c_expanded.rs2} = mem_off;
    end else if (key5 == C_SW) begin
      c_expanded.opcode = OP_STORE;
      c_expanded.funct3 = F3_SW;
      c_expanded.rs1    = rs1_prime;
      c_expanded.rs2    = rs2_prime;
      {c_expanded.funct7, c_expanded.rd} = mem_off;
    end else if (key5 == C_ADDI || key5 == C_LI) begin
      // C.LI is addi from x0
      c_expanded.opcode = OP_OP_IMM;
      c_expanded.funct3 = F3_ADD_SUB;
      c_expanded.rd     = rd_full;
      c_expanded.rs1    = (key5 == C_LI) ? 5'd0 : rd_full;
      {c_expanded.funct7, c_expanded.rs2} = imm6_sext;
    end else if (key5 == C_LUI && rd_full != 5'd2 && {c_instr[12], rs2_full} != '0) begin
      c_expanded.opcode = OP_LUI;
      c_expanded.rd     = rd_full;
      {c_expanded.funct7, c_expanded.rs2, c_expanded.rs1, c_expanded.funct3} = lui_imm;
    end else if (key5 == C_BEQZ || key5 == C_BNEZ) begin
      c_expanded.opcode = OP_BRANCH;
      c_expanded.funct3 = (key5 == C_BNEZ) ? F3_BNE : F3_BEQ;
      c_expanded.rs1    = rs1_prime;
      c_expanded.funct7 = {br_off[12], br_off[10:5]};
      c_expanded.rd     = {br_off[4:1], br_off[11]};
    end else if (key5 == C_SLLI && !c_instr[12]) begin
      // shamt[5] set is reserved on RV32
      c_expanded.opcode = OP_OP_IMM;
      c_expanded.funct3 = F3_SLL;
      c_expanded.funct7 = F7_SLL;
      c_expanded.rd     = rd_full;
      c_expanded.rs1    = rd_full;
      c_expanded.rs2    = rs2_full;
    end else if ((key6 == C_ADD || key6 == C_MV) && rs2_full != '0) begin
      c_expanded.opcode = OP_OP;
      c_expanded.funct3 = F3_ADD_SUB;
      c_expanded.funct7 = F7_ADD;
      c_expanded.rd     = rd_full;
      c_expanded.rs1    = (key6 == C_MV) ? 5'd0 : rd_full;
      c_expanded.rs2    = rs2_full;
    end else if ((key7 == C_SRLI || key7 == C_SRAI) && !c_instr[12]) begin
      c_expanded.opcode = OP_OP_IMM;
      c_expanded.funct3 = F3_SRL_SRA;
      c_expanded.funct7 = (key7 == C_SRAI) ? F7_SRA : F7_SRL;
      c_expanded.rd     = rs1_prime;
      c_expanded.rs1    = rs1_prime;
      c_expanded.rs2    = rs2_full;
    end else if (key7 == C_ANDI) begin
      c_expanded.opcode = OP_OP_IMM;
      c_expanded.funct3 = F3_AND;
      c_expanded.rd     = rs1_prime;
      c_expanded.rs1    = rs1_prime;
      {c_expanded.funct7, c_expanded.rs2} = imm6_sext;
    end else if (key10 inside {C_SUB, C_XOR, C_OR, C_AND}) begin
      c_expanded.opcode = OP_OP;
      c_expanded.rd     = rs1_prime;
      c_expanded.rs1    = rs1_prime;
      c_expanded.rs2    = rs2_prime;
      case (key10)
        C_SUB: begin
          c_expanded.funct3 = F3_ADD_SUB;
          c_expanded.funct7 = F7_SUB;
        end
        C_XOR: c_expanded.funct3 = F3_XOR;
        C_OR:  c_expanded.funct3 = F3_OR;
        default: begin
          c_expanded.funct3 = F3_AND;
          c_expanded.funct7 = F7_LOGIC;
        end
      endcase
    end else begin
      // Anything else, the zero halfword included
      c_illegal = 1'b1;
    end
  end

endmodule

// ==== design/fetch_frontend.sv ====
`timescale 1ns/100ps

module fetch_frontend (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 word_valid,
  input  rvc_pkg::fetch_word_t word,
  input  logic                 dec_credit,
  output logic                 word_credit,
  output logic                 instr_valid,
  output rvc_pkg::issue_t      instr
);
  import rvc_pkg::*;

  logic            q_valid;
  logic            q_pop;
  fetch_word_t     q_word;
  logic [15:0]     c_instr;
  instruction_type c_expanded;
  logic            c_illegal;

  fetch_queue i_fetch_queue (
    .clk         (clk),
    .rst_n       (rst_n),
    .word_valid  (word_valid),
    .word        (word),
    .q_pop       (q_pop),
    .word_credit (word_credit),
    .q_valid     (q_valid),
    .q_word      (q_word)
  );

  instr_aligner i_instr_aligner (
    .clk         (clk),
    .rst_n       (rst_n),
    .q_valid     (q_valid),
    .q_word      (q_word),
    .c_expanded  (c_expanded),
    .c_illegal   (c_illegal),
    .dec_credit  (dec_credit),
    .q_pop       (q_pop),
    .c_instr     (c_instr),
    .instr_valid (instr_valid),
    .instr       (instr)
  );

  decompressor i_decompressor (
    .c_instr    (c_instr),
    .c_expanded (c_expanded),
    .c_illegal  (c_illegal)
  );

endmodule

// ==== design/fetch_queue.sv ====
`timescale 1ns/100ps

module fetch_queue (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 word_valid,
  input  rvc_pkg::fetch_word_t word,
  input  logic                 q_pop,
  output logic                 word_credit,
  output logic                 q_valid,
  output rvc_pkg::fetch_word_t q_word
);
  import rvc_pkg::*;

  fetch_word_t            mem [FETCH_DEPTH];
  logic [FETCH_PTR_W-1:0] wr_ptr;
  logic [FETCH_PTR_W-1:0] rd_ptr;
  logic [FETCH_CNT_W-1:0] count;
  logic                   full;

  assign full    = (count == FETCH_CNT_W'(FETCH_DEPTH));
  assign q_valid = (count != '0);
  assign q_word  = mem[rd_ptr];

  // Storage holds payload only
  always_ff @(posedge clk) begin
    if (word_valid) begin
      mem[wr_ptr] <= word;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr      <= '0;
      rd_ptr      <= '0;
      count       <= '0;
      word_credit <= 1'b0;
    end else begin
      if (word_valid) begin
        wr_ptr <= (wr_ptr == FETCH_PTR_W'(FETCH_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (q_pop) begin
        rd_ptr <= (rd_ptr == FETCH_PTR_W'(FETCH_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({word_valid, q_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      // One credit back to memory per freed slot
      word_credit <= q_pop;
    end
  end

  // Memory must stay within its credits
  a_no_push_full: assert property (
    @(posedge clk) disable iff (!rst_n) word_valid |-> !full
  ) else $error("fetch_queue: push into full queue");

  // Aligner pops only a presented word
  a_no_pop_empty: assert property (
    @(posedge clk) disable iff (!rst_n) q_pop |-> q_valid
  ) else $error("fetch_queue: pop from empty queue");

endmodule

// ==== design/instr_aligner.sv ====
`timescale 1ns/100ps

module instr_aligner (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     q_valid,
  input  rvc_pkg::fetch_word_t     q_word,
  input  rvc_pkg::instruction_type c_expanded,
  input  logic                     c_illegal,
  input  logic                     dec_credit,
  output logic                     q_pop,
  output logic [15:0]              c_instr,
  output logic                     instr_valid,
  output rvc_pkg::issue_t          instr
);
  import rvc_pkg::*;

  logic [15:0]         spare_hw;
  logic                hw_valid;
  logic [31:0]         pc;
  logic [CREDIT_W-1:0] credits;
  logic [15:0]         cur_hw;
  logic [31:0]         full_word;
  logic                is_rvc;
  logic                have_instr;
  logic                take;
  issue_t              issue_next;

  // Oldest halfword comes from the spare when it holds one
  assign cur_hw    = hw_valid ? spare_hw : q_word.data[15:0];
  assign c_instr   = cur_hw;
  assign is_rvc    = (cur_hw[1:0] != 2'b11);
  assign full_word = hw_valid ? {q_word.data[15:0], spare_hw} : q_word.data;

  // A 32-bit instruction in the spare needs the next word too
  assign have_instr = hw_valid ? (is_rvc || q_valid) : q_valid;
  assign take       = have_instr && (credits != '0);

  // Word leaves once its halfwords are issued or parked in the spare
  assign q_pop = take && (!hw_valid || !is_rvc);

  always_comb begin
    issue_next.pc         = pc;
    issue_next.instr      = is_rvc ? c_expanded : instruction_type'(full_word);
    issue_next.compressed = is_rvc;
    issue_next.illegal    = is_rvc && c_illegal;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      hw_valid    <= 1'b0;
      pc          <= RESET_PC;
      credits     <= '0;
      instr_valid <= 1'b0;
    end else begin
      instr_valid <= take;
      credits     <= credits + CREDIT_W'(dec_credit) - CREDIT_W'(take);
      if (take) begin
        pc       <= pc + (is_rvc ? 32'd2 : 32'd4);
        // Spare state flips on a compressed issue, holds on a full one
        hw_valid <= hw_valid ^ is_rvc;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (q_pop) begin
      spare_hw <= q_word.data[31:16];
    end
    if (take) begin
      instr <= issue_next;
    end
  end

  // Issue only against a credit held the cycle before
  a_issue_credit: assert property (
    @(posedge clk) disable iff (!rst_n) instr_valid |-> $past(credits) != '0
  ) else $error("instr_aligner: issue without decoder credit");

  // Granted credit must not wrap the counter
  a_credit_overflow: assert property (
    @(posedge clk) disable iff (!rst_n) (dec_credit && !take) |=> credits != '0
  ) else $error("instr_aligner: decoder credit counter overflow");

endmodule

// ==== design/rvc_pkg.sv ====
package rvc_pkg;

  // RV32I instruction in R-type field order
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } instruction_type;

  // Issue record sent to the decoder
  typedef struct packed {
    logic [31:0]     pc;
    instruction_type instr;
    logic            compressed;
    logic            illegal;
  } issue_t;

  // Word from instruction memory
  typedef struct packed {
    logic [31:0] data;
  } fetch_word_t;

  // Queue depth, also the memory credits after reset
  localparam int FETCH_DEPTH = 4;
  localparam int FETCH_PTR_W = $clog2(FETCH_DEPTH);
  localparam int FETCH_CNT_W = $clog2(FETCH_DEPTH + 1);

  // Decoder credit counter width
  localparam int CREDIT_W = 8;

  localparam logic [31:0] RESET_PC = 32'h0000_0000;

  // RV32I opcodes
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_OP     = 7'b0110011;
  localparam logic [6:0] OP_OP_IMM = 7'b0010011;
  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;

  // Funct3 codes
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SRL_SRA = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;
  localparam logic [2:0] F3_LW      = 3'b010;
  localparam logic [2:0] F3_SW      = 3'b010;
  localparam logic [2:0] F3_BEQ     = 3'b000;
  localparam logic [2:0] F3_BNE     = 3'b001;

  // Funct7 codes, shifts carry theirs in the upper immediate bits
  localparam logic [6:0] F7_ADD   = 7'b0000000;
  localparam logic [6:0] F7_SUB   = 7'b0100000;
  localparam logic [6:0] F7_LOGIC = 7'b0000000;
  localparam logic [6:0] F7_SLL   = 7'b0000000;
  localparam logic [6:0] F7_SRL   = 7'b0000000;
  localparam logic [6:0] F7_SRA   = 7'b0100000;

endpackage

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the fetch front end regression with Verilator
set -e

verilator --binary --timing --assert -f sources.f --top-module tb_fetch_frontend -o sim_fetch

./obj_dir/sim_fetch > sim.log 2>&1 || true
cat sim.log

if grep -q "Regression passed" sim.log; then
  exit 0
else
  exit 1
fi

// ==== sim/expand_model.svh ====
// Builds one compressed encoding and its RV32I expansion, returned as {halfword, expansion}
// Kinds 0 to 16: LW SW ADDI LI LUI SLLI SRLI SRAI ANDI SUB XOR OR AND BEQZ BNEZ MV ADD
function automatic logic [47:0] rvc_encode(input int kind, input logic [31:0] r);
  logic [4:0]  rd;
  logic [4:0]  rs;
  logic [2:0]  p1;
  logic [2:0]  p2;
  logic [5:0]  i6;
  logic [11:0] s12;
  logic [4:0]  u;
  logic [11:0] uoff;
  logic [12:0] b;
  logic [1:0]  f2;
  logic [15:0] h;
  logic [31:0] e;
  // rd avoids x0 and x2 so C.LUI stays legal
  rd   = (r[4:0] == 5'd0 || r[4:0] == 5'd2) ? 5'd9 : r[4:0];
  rs   = (r[9:5] == 5'd0) ? 5'd1 : r[9:5];
  p1   = r[12:10];
  p2   = r[15:13];
  i6   = (r[21:16] == 6'd0) ? 6'h21 : r[21:16];
  s12  = {{6{i6[5]}}, i6};
  u    = r[26:22];
  uoff = {5'b0, u, 2'b00};
  b    = {{4{r[31]}}, r[31:24], 1'b0};
  f2   = 2'(kind - 9);
  h    = '0;
  e    = '0;
  case (kind)
    0: begin
      h = {3'b010, u[3:1], p1, u[0], u[4], p2, 2'b00};
      e = {uoff, 2'b01, p1, 3'b010, 2'b01, p2, OP_LOAD};
    end
    1: begin
      h = {3'b110, u[3:1], p1, u[0], u[4], p2, 2'b00};
      e = {uoff[11:5], 2'b01, p2, 2'b01, p1, 3'b010, uoff[4:0], OP_STORE};
    end
    2: begin
      h = {3'b000, i6[5], rd, i6[4:0], 2'b01};
      e = {s12, rd, 3'b000, rd, OP_OP_IMM};
    end
    3: begin
      h = {3'b010, i6[5], rd, i6[4:0], 2'b01};
      e = {s12, 5'd0, 3'b000, rd, OP_OP_IMM};
    end
    4: begin
      h = {3'b011, i6[5], rd, i6[4:0], 2'b01};
      e = {{14{i6[5]}}, i6, rd, OP_LUI};
    end
    5: begin
      h = {3'b000, 1'b0, rd, i6[4:0], 2'b10};
      e = {7'b0000000, i6[4:0], rd, 3'b001, rd, OP_OP_IMM};
    end
    6: begin
      h = {3'b100, 1'b0, 2'b00, p1, i6[4:0], 2'b01};
      e = {7'b0000000, i6[4:0], 2'b01, p1, 3'b101, 2'b01, p1, OP_OP_IMM};
    end
    7: begin
      h = {3'b100, 1'b0, 2'b01, p1, i6[4:0], 2'b01};
      e = {7'b0100000, i6[4:0], 2'b01, p1, 3'b101, 2'b01, p1, OP_OP_IMM};
    end
    8: begin
      h = {3'b100, i6[5], 2'b10, p1, i6[4:0], 2'b01};
      e = {s12, 2'b01, p1, 3'b111, 2'b01, p1, OP_OP_IMM};
    end
    9, 10, 11, 12: begin
      h = {6'b100011, p1, f2, p2, 2'b01};
      case (f2)
        2'd0:    e = {7'b0100000, 2'b01, p2, 2'b01, p1, 3'b000, 2'b01, p1, OP_OP};
        2'd1:    e = {7'b0000000, 2'b01, p2, 2'b01, p1, 3'b100, 2'b01, p1, OP_OP};
        2'd2:    e = {7'b0000000, 2'b01, p2, 2'b01, p1, 3'b110, 2'b01, p1, OP_OP};
        default: e = {7'b0000000, 2'b01, p2, 2'b01, p1, 3'b111, 2'b01, p1, OP_OP};
      endcase
    end
    13, 14: begin
      h = {2'b11, kind == 14, b[8], b[4:3], p1, b[7:6], b[2:1], b[5], 2'b01};
      e = {b[12], b[10:5], 5'd0, 2'b01, p1, 2'b00, kind == 14, b[4:1], b[11], OP_BRANCH};
    end
    15: begin
      h = {4'b1000, rd, rs, 2'b10};
      e = {7'b0000000, rs, 5'd0, 3'b000, rd, OP_OP};
    end
    default: begin
      h = {4'b1001, rd, rs, 2'b10};
      e = {7'b0000000, rs, rd, 3'b000, rd, OP_OP};
    end
  endcase
  return {h, e};
endfunction

// ==== sim/tb_fetch_frontend.sv ====
`timescale 1ns/100ps

module tb_fetch_frontend;
  import rvc_pkg::*;
  `include "expand_model.svh"

  localparam int MAX_INSTR = 256;

  logic        clk;
  logic        rst_n;
  logic        word_valid;
  fetch_word_t word;
  logic        dec_credit;
  logic        word_credit;
  logic        instr_valid;
  issue_t      instr;

  issue_t      exp_mem [MAX_INSTR];
  issue_t      exp_head;
  logic [31:0] prog_words [MAX_INSTR];
  logic [15:0] hw_q [$];
  logic [31:0] build_pc;
  logic        seen_input;
  logic        dec_credit_d;
  int          exp_count;
  int          exp_idx;
  int          n_words;
  int          words_sent;
  int          credit_returns;
  int          mem_credits;
  int          dec_held;

  fetch_frontend i_fetch_frontend (
    .clk         (clk),
    .rst_n       (rst_n),
    .word_valid  (word_valid),
    .word        (word),
    .dec_credit  (dec_credit),
    .word_credit (word_credit),
    .instr_valid (instr_valid),
    .instr       (instr)
  );

  assign exp_head = exp_mem[exp_idx];

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Regression failed");
    $fatal(1);
  endtask

  // Scoreboard pointer plus memory and decoder credit bookkeeping
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      exp_idx        <= 0;
      words_sent     <= 0;
      credit_returns <= 0;
      mem_credits    <= FETCH_DEPTH;
      dec_held       <= 0;
      seen_input     <= 1'b0;
      dec_credit_d   <= 1'b0;
    end else begin
      if (instr_valid) begin
        exp_idx <= exp_idx + 1;
      end
      if (word_valid || dec_credit) begin
        seen_input <= 1'b1;
      end
      words_sent     <= words_sent + int'(word_valid);
      credit_returns <= credit_returns + int'(word_credit);
      mem_credits    <= mem_credits - int'(word_valid) + int'(word_credit);
      dec_held       <= dec_held + int'(dec_credit) - int'(instr_valid);
      dec_credit_d   <= dec_credit;
    end
  end

  a_quiet_after_reset: assert property (
    @(posedge clk) disable iff (!rst_n) !seen_input |-> (!word_credit && !instr_valid)
  ) else abort_run($sformatf("ERROR %0t word_credit/instr_valid expected 0/0 got %b/%b",
                             $time, $sampled(word_credit), $sampled(instr_valid)));

  a_issue_order: assert property (
    @(posedge clk) disable iff (!rst_n) instr_valid |-> (exp_idx < exp_count && instr == exp_head)
  ) else abort_run($sformatf("ERROR %0t instr expected %h got %h",
                             $time, $sampled(exp_head), $sampled(instr)));

  // A grant sampled on the issue edge was not yet held
  a_issue_credit: assert property (
    @(posedge clk) disable iff (!rst_n) instr_valid |-> (dec_held - int'(dec_credit_d)) > 0
  ) else abort_run($sformatf("ERROR %0t dec_held before issue expected >0 got %0d", $time,
                             $sampled(dec_held) - int'($sampled(dec_credit_d))));

  a_mem_outstanding: assert property (
    @(posedge clk) disable iff (!rst_n)
      (words_sent >= credit_returns) && (words_sent - credit_returns <= FETCH_DEPTH)
  ) else abort_run($sformatf("ERROR %0t outstanding words expected 0 to %0d got %0d", $time,
                             FETCH_DEPTH, $sampled(words_sent) - $sampled(credit_returns)));

  task automatic add_instr(input logic [31:0] enc, input bit is16, input logic [31:0] exp_val,
                           input bit bad);
    issue_t e;
    e.pc         = build_pc;
    e.instr      = instruction_type'(exp_val);
    e.compressed = is16;
    e.illegal    = bad;
    exp_mem[exp_count] = e;
    exp_count++;
    hw_q.push_back(enc[15:0]);
    if (!is16) begin
      hw_q.push_back(enc[31:16]);
    end
    build_pc += is16 ? 32'd2 : 32'd4;
  endtask

  task automatic add_rvc(input int kind);
    logic [47:0] v;
    v = rvc_encode(kind, $urandom());
    add_instr({16'h0000, v[47:32]}, 1'b1, v[31:0], 1'b0);
  endtask

  task automatic add_full();
    logic [31:0] r;
    r = $urandom() | 32'h0000_0003;
    add_instr(r, 1'b0, r, 1'b0);
  endtask

  task automatic build_program();
    for (int i = 0; i < 8; i++) begin
      add_full();
    end
    // A 32-bit instruction after every third one lands across a word boundary
    for (int rep = 0; rep < 3; rep++) begin
      for (int k = 0; k < 17; k++) begin
        add_rvc(k);
        if (k % 3 == 0) begin
          add_full();
        end
      end
    end
    add_instr(32'h0000_0000, 1'b1, 32'h0, 1'b1);
    add_instr(32'h0000_2001, 1'b1, 32'h0, 1'b1);
    add_instr(32'h0000_6101, 1'b1, 32'h0, 1'b1);
    for (int i = 0; i < 40; i++) begin
      if ($urandom_range(0, 1) == 0) begin
        add_rvc(int'($urandom_range(0, 16)));
      end else begin
        add_full();
      end
    end
    if (hw_q.size() % 2 != 0) begin
      add_rvc(2);
    end
    n_words = hw_q.size() / 2;
    for (int i = 0; i < n_words; i++) begin
      prog_words[i] = {hw_q[2*i+1], hw_q[2*i]};
    end
  endtask

  // Memory sends only while it holds a credit
  task automatic drive_memory();
    int idx;
    idx = 0;
    while (idx < n_words) begin
      @(posedge clk);
      #1;
      if (mem_credits > 0 && $urandom_range(0, 3) != 0) begin
        word_valid = 1'b1;
        word.data  = prog_words[idx];
        idx++;
      end else begin
        word_valid = 1'b0;
      end
    end
    @(posedge clk);
    #1 word_valid = 1'b0;
  endtask

  // Bursts of random grants, then long stretches with none
  task automatic grant_credits();
    int burst;
    int hold;
    forever begin
      burst = int'($urandom_range(1, 30));
      hold  = int'($urandom_range(0, 50));
      repeat (burst) begin
        @(posedge clk);
        #1 dec_credit = (dec_held < 12) && ($urandom_range(0, 1) == 1);
      end
      repeat (hold) begin
        @(posedge clk);
        #1 dec_credit = 1'b0;
      end
    end
  endtask

  initial begin
    void'($urandom(89));
    rst_n      = 1'b0;
    word_valid = 1'b0;
    word       = '0;
    dec_credit = 1'b0;
    exp_count  = 0;
    n_words    = 0;
    build_pc   = RESET_PC;
    build_program();
    repeat (2) @(posedge clk);
    #1 rst_n = 1'b1;
    repeat (5) @(posedge clk);
    fork
      drive_memory();
      grant_credits();
    join_none
    wait (exp_idx == exp_count);
    repeat (10) @(posedge clk);
    if (credit_returns == words_sent && words_sent == n_words) begin
      $display("Regression passed");
      $finish;
    end else begin
      abort_run($sformatf("word_credit pulses (%0d) do not match words sent (%0d of %0d)",
                          credit_returns, words_sent, n_words));
    end
  end

  initial begin
    wait (n_words > 0);
    repeat (40 * n_words + 200) @(posedge clk);
    abort_run("Watchdog timeout, not all instructions reached the decoder");
  end

endmodule

// ==== sources.f ====
+incdir+sim
design/rvc_pkg.sv
design/fetch_queue.sv
design/decompressor.sv
design/instr_aligner.sv
design/fetch_frontend.sv
sim/tb_fetch_frontend.sv
